/* hw/fifo_consts.svh */
`ifndef FIFO_CONSTS_SVH
`define FIFO_CONSTS_SVH

// ------------------------------------------------------------
// RAM geometry
// ------------------------------------------------------------

// Number of RAM entries
// Power of two and at least 2 so the pointers wrap on their own
`define FIFO_DEPTH 8

// Data bits per entry
`define FIFO_WIDTH 16

// ------------------------------------------------------------
// RAM pipelining and options
// ------------------------------------------------------------

// Register stages on the write and read address paths
`define FIFO_ADDR_STAGES 1

// Register stages on the read data path
`define FIFO_RD_DATA_STAGES 1

// Cycles from read issue to read data valid
`define FIFO_RD_LATENCY (`FIFO_ADDR_STAGES + `FIFO_RD_DATA_STAGES)

// Read returns same-cycle write data on an address match
`define FIFO_TILE_BYPASS 0

// Zero the memory on reset
`define FIFO_MEM_RESET 1

// One slot per read in flight plus one for the head
`define FIFO_POP_BUF_DEPTH (`FIFO_RD_LATENCY + 1)

`endif

/* hw/fifo_pkg.sv */
package fifo_pkg;

  `include "fifo_consts.svh"

  // ------------------------------------------------------------
  // Widths derived from the header
  // ------------------------------------------------------------

  localparam int addr_w = $clog2(`FIFO_DEPTH);

  // One extra bit so the count can reach FIFO_DEPTH
  localparam int count_w = addr_w + 1;

  // ------------------------------------------------------------
  // Types
  // ------------------------------------------------------------

  typedef logic [addr_w-1:0] addr_t;

  typedef logic [`FIFO_WIDTH-1:0] data_t;

  typedef logic [count_w-1:0] count_t;

  // Write request carried down the RAM write pipeline
  typedef struct packed {
    addr_t addr;
    data_t data;
  } wr_req_t;

  // Controller states
  typedef enum logic [1:0] {
    EMPTY  = 2'd0,
    ACTIVE = 2'd1,
    FULL   = 2'd2,
    DRAIN  = 2'd3
  } ctrl_state_t;

endpackage

/* hw/delay_valid.sv */
`timescale 1ns/1ps

module delay_valid #(
  parameter type payload_t = logic,
  parameter int  num_stages = 1
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     in_valid,
  input  payload_t in_payload,
  output logic     out_valid,
  output payload_t out_payload
);

  if (num_stages == 0) begin : gen_pass
    // No stages so valid and payload go straight through
    assign out_valid   = in_valid;
    assign out_payload = in_payload;
  end else begin : gen_pipe
    logic [num_stages-1:0] valid_q;
    payload_t              payload_q [num_stages];

    // ------------------------------------------------------------
    // Valid chain
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
      if (rst) begin
        valid_q <= '0;
      end else begin
        valid_q[0] <= in_valid;
        for (int i = 1; i < num_stages; i++) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end

    // ------------------------------------------------------------
    // Payload chain
    // ------------------------------------------------------------
    // Each stage only loads when its input is valid
    always_ff @(posedge clk) begin
      if (in_valid) begin
        payload_q[0] <= in_payload;
      end
      for (int i = 1; i < num_stages; i++) begin
        if (valid_q[i-1]) begin
          payload_q[i] <= payload_q[i-1];
        end
      end
    end

    assign out_valid   = valid_q[num_stages-1];
    assign out_payload = payload_q[num_stages-1];
  end

endmodule

/* hw/ram_flops_1r1w.sv */
`timescale 1ns/1ps

module ram_flops_1r1w #(
  parameter int depth          = 8,
  parameter int width          = 16,
  parameter int addr_stages    = 1,
  parameter int rd_data_stages = 1,
  parameter bit tile_bypass    = 1'b0,
  parameter bit mem_reset      = 1'b0
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            wr_valid,
  input  fifo_pkg::addr_t wr_addr,
  input  fifo_pkg::data_t wr_data,
  input  logic            rd_addr_valid,
  input  fifo_pkg::addr_t rd_addr,
  output logic            rd_data_valid,
  output fifo_pkg::data_t rd_data
);

  fifo_pkg::wr_req_t wr_req;
  fifo_pkg::wr_req_t mem_wr_req;
  logic              mem_wr_valid;
  logic              mem_rd_addr_valid;
  fifo_pkg::addr_t   mem_rd_addr;
  fifo_pkg::data_t   mem_rd_data;
  logic [width-1:0]  mem [depth];

  // ------------------------------------------------------------
  // Address pipelines
  // ------------------------------------------------------------
  // Address and data of a write travel together
  assign wr_req.addr = wr_addr;
  assign wr_req.data = wr_data;

  delay_valid #(
    .payload_t  (fifo_pkg::wr_req_t),
    .num_stages (addr_stages)
  ) wr_delay_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (wr_valid),
    .in_payload  (wr_req),
    .out_valid   (mem_wr_valid),
    .out_payload (mem_wr_req)
  );

  delay_valid #(
    .payload_t  (fifo_pkg::addr_t),
    .num_stages (addr_stages)
  ) rd_addr_delay_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (rd_addr_valid),
    .in_payload  (rd_addr),
    .out_valid   (mem_rd_addr_valid),
    .out_payload (mem_rd_addr)
  );

  // ------------------------------------------------------------
  // Storage and write port
  // ------------------------------------------------------------
  for (genvar i = 0; i < depth; i++) begin : gen_mem
    if (mem_reset) begin : gen_reset
      always_ff @(posedge clk) begin
        if (rst) begin
          mem[i] <= '0;
        end else if (mem_wr_valid && (mem_wr_req.addr == i)) begin
          mem[i] <= mem_wr_req.data;
        end
      end
    end else begin : gen_no_reset
      always_ff @(posedge clk) begin
        if (mem_wr_valid && (mem_wr_req.addr == i)) begin
          mem[i] <= mem_wr_req.data;
        end
      end
    end
  end

  // ------------------------------------------------------------
  // Read port
  // ------------------------------------------------------------
  if (tile_bypass) begin : gen_bypass
    // Same-cycle write to the read address wins over the stored word
    assign mem_rd_data = (mem_wr_valid && (mem_wr_req.addr == mem_rd_addr)) ?
                         mem_wr_req.data : mem[mem_rd_addr];
  end else begin : gen_no_bypass
    assign mem_rd_data = mem[mem_rd_addr];
  end

  // Read data pipeline back to the consumer
  delay_valid #(
    .payload_t  (fifo_pkg::data_t),
    .num_stages (rd_data_stages)
  ) rd_data_delay_i (
    .clk         (clk),
    .rst         (rst),
    .in_valid    (mem_rd_addr_valid),
    .in_payload  (mem_rd_data),
    .out_valid   (rd_data_valid),
    .out_payload (rd_data)
  );

endmodule

/* hw/fifo_occupancy.sv */
`timescale 1ns/1ps

`include "fifo_consts.svh"

module fifo_occupancy (
  input  logic            clk,
  input  logic            rst,
  input  logic            clear,
  input  logic            push_fire,
  input  logic            rd_issue,
  output fifo_pkg::addr_t wr_addr,
  output fifo_pkg::addr_t rd_addr,
  output logic            empty,
  output logic            full
);

  fifo_pkg::count_t count;
  fifo_pkg::count_t count_next;

  // Push and read may land in the same cycle
  assign count_next = count + fifo_pkg::count_t'(push_fire) - fifo_pkg::count_t'(rd_issue);

  // ------------------------------------------------------------
  // Pointers
  // ------------------------------------------------------------
  // Depth is a power of two so the pointers wrap naturally
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_addr <= '0;
      rd_addr <= '0;
    end else begin
      if (push_fire) begin
        wr_addr <= wr_addr + 1'b1;
      end
      if (rd_issue) begin
        rd_addr <= rd_addr + 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Entry count and flags
  // ------------------------------------------------------------
  // Flags come from the next count
  // so they line up with the count register
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      count <= '0;
      empty <= 1'b1;
      full  <= 1'b0;
    end else begin
      count <= count_next;
      empty <= (count_next == '0);
      full  <= (count_next == fifo_pkg::count_t'(`FIFO_DEPTH));
    end
  end

endmodule

/* hw/fifo_ctrl_fsm.sv */
`timescale 1ns/1ps

module fifo_ctrl_fsm (
  input  logic clk,
  input  logic rst,
  input  logic flush,
  input  logic empty,
  input  logic full,
  input  logic credit_ok,
  input  logic in_flight_zero,
  output logic push_ready,
  output logic rd_issue,
  output logic clear
);

  fifo_pkg::ctrl_state_t state;
  fifo_pkg::ctrl_state_t state_next;
  fifo_pkg::ctrl_state_t fill_state;

  // Fill level as seen from the occupancy flags
  assign fill_state = full ? fifo_pkg::FULL : (empty ? fifo_pkg::EMPTY : fifo_pkg::ACTIVE);

  // ------------------------------------------------------------
  // Next state and outputs
  // ------------------------------------------------------------
  always_comb begin
    state_next = state;
    push_ready = 1'b0;
    rd_issue   = 1'b0;
    clear      = 1'b0;
    case (state)
      fifo_pkg::EMPTY, fifo_pkg::ACTIVE: begin
        // In EMPTY the first entry is read as soon as the count shows it
        push_ready = !full && !flush;
        rd_issue   = !empty && credit_ok && !flush;
        state_next = flush ? fifo_pkg::DRAIN : fill_state;
      end
      fifo_pkg::FULL: begin
        // Pushes wait until a read frees a RAM entry
        rd_issue   = !empty && credit_ok && !flush;
        state_next = flush ? fifo_pkg::DRAIN : fill_state;
      end
      fifo_pkg::DRAIN: begin
        // Hold until the RAM reads in flight have returned
        if (in_flight_zero) begin
          clear      = 1'b1;
          state_next = fifo_pkg::EMPTY;
        end
      end
      default: begin
        state_next = fifo_pkg::EMPTY;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= fifo_pkg::EMPTY;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* hw/fifo_pop_buffer.sv */
`timescale 1ns/1ps

module fifo_pop_buffer #(
  parameter int entries = 3
) (
  input  logic            clk,
  input  logic            rst,
  input  logic            clear,
  input  logic            rd_issue,
  input  logic            rd_data_valid,
  input  fifo_pkg::data_t rd_data,
  output logic            pop_valid,
  input  logic            pop_ready,
  output fifo_pkg::data_t pop_data,
  output logic            credit_ok,
  output logic            in_flight_zero
);

  localparam int ptr_w = (entries > 1) ? $clog2(entries) : 1;
  localparam int cnt_w = $clog2(entries + 1);

  fifo_pkg::data_t  store [entries];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  logic [cnt_w-1:0] held;
  logic [cnt_w-1:0] in_flight;
  logic [cnt_w-1:0] in_flight_next;
  logic [cnt_w-1:0] drop_cnt;
  logic             keep;
  logic             pop_fire;

  // Head entry stays put until it is taken
  assign pop_valid = (held != '0);
  assign pop_data  = store[rd_ptr];
  assign pop_fire  = pop_valid && pop_ready;

  // Reads issued before a clear are dropped on arrival
  assign keep = rd_data_valid && (drop_cnt == '0);

  assign in_flight_next = in_flight + cnt_w'(rd_issue) - cnt_w'(rd_data_valid);

  // Every read in flight already owns a slot
  assign credit_ok      = (int'(held) + int'(in_flight)) < entries;
  assign in_flight_zero = (in_flight == '0);

  // ------------------------------------------------------------
  // Read reservations
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst) begin
      in_flight <= '0;
      drop_cnt  <= '0;
    end else begin
      in_flight <= in_flight_next;
      if (clear) begin
        drop_cnt <= in_flight_next;
      end else if (rd_data_valid && (drop_cnt != '0)) begin
        drop_cnt <= drop_cnt - 1'b1;
      end
    end
  end

  // ------------------------------------------------------------
  // Circular storage
  // ------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (rst || clear) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      held   <= '0;
    end else begin
      if (keep) begin
        wr_ptr <= (wr_ptr == ptr_w'(entries - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop_fire) begin
        rd_ptr <= (rd_ptr == ptr_w'(entries - 1)) ? '0 : rd_ptr + 1'b1;
      end
      held <= held + cnt_w'(keep) - cnt_w'(pop_fire);
    end
  end

  always_ff @(posedge clk) begin
    if (keep) begin
      store[wr_ptr] <= rd_data;
    end
  end

endmodule

/* hw/flop_fifo.sv */
`timescale 1ns/1ps

`include "fifo_consts.svh"

module flop_fifo (
  input  logic            clk,
  input  logic            rst,
  input  logic            push_valid,
  output logic            push_ready,
  input  fifo_pkg::data_t push_data,
  output logic            pop_valid,
  input  logic            pop_ready,
  output fifo_pkg::data_t pop_data,
  input  logic            flush
);

  logic            push_fire;
  logic            rd_issue;
  logic            empty;
  logic            full;
  logic            credit_ok;
  logic            in_flight_zero;
  logic            clear;
  fifo_pkg::addr_t wr_addr;
  fifo_pkg::addr_t rd_addr;
  logic            rd_data_valid;
  fifo_pkg::data_t rd_data;

  assign push_fire = push_valid && push_ready;

  // ------------------------------------------------------------
  // Control
  // ------------------------------------------------------------
  fifo_ctrl_fsm ctrl_i (
    .clk            (clk),
    .rst            (rst),
    .flush          (flush),
    .empty          (empty),
    .full           (full),
    .credit_ok      (credit_ok),
    .in_flight_zero (in_flight_zero),
    .push_ready     (push_ready),
    .rd_issue       (rd_issue),
    .clear          (clear)
  );

  fifo_occupancy occupancy_i (
    .clk       (clk),
    .rst       (rst),
    .clear     (clear),
    .push_fire (push_fire),
    .rd_issue  (rd_issue),
    .wr_addr   (wr_addr),
    .rd_addr   (rd_addr),
    .empty     (empty),
    .full      (full)
  );

  // ------------------------------------------------------------
  // Datapath
  // ------------------------------------------------------------
  ram_flops_1r1w #(
    .depth          (`FIFO_DEPTH),
    .width          (`FIFO_WIDTH),
    .addr_stages    (`FIFO_ADDR_STAGES),
    .rd_data_stages (`FIFO_RD_DATA_STAGES),
    .tile_bypass    (`FIFO_TILE_BYPASS),
    .mem_reset      (`FIFO_MEM_RESET)
  ) ram_i (
    .clk           (clk),
    .rst           (rst),
    .wr_valid      (push_fire),
    .wr_addr       (wr_addr),
    .wr_data       (push_data),
    .rd_addr_valid (rd_issue),
    .rd_addr       (rd_addr),
    .rd_data_valid (rd_data_valid),
    .rd_data       (rd_data)
  );

  // Absorbs the RAM read latency under pop back-pressure
  fifo_pop_buffer #(
    .entries (`FIFO_POP_BUF_DEPTH)
  ) pop_buffer_i (
    .clk            (clk),
    .rst            (rst),
    .clear          (clear),
    .rd_issue       (rd_issue),
    .rd_data_valid  (rd_data_valid),
    .rd_data        (rd_data),
    .pop_valid      (pop_valid),
    .pop_ready      (pop_ready),
    .pop_data       (pop_data),
    .credit_ok      (credit_ok),
    .in_flight_zero (in_flight_zero)
  );

endmodule

/* bench/tb_clock.sv */
`timescale 1ns/1ps

module tb_clock #(
  parameter int period_ns = 40
) (
  output logic clk
);

  // Free running clock, low for the first half period
  initial begin
    clk = 1'b0;
    forever begin
      #(period_ns / 2) clk = ~clk;
    end
  end

endmodule

/* bench/flop_fifo_tb.sv */
`timescale 1ns/1ps

`include "fifo_consts.svh"

module flop_fifo_tb;

  typedef enum int {
    OP_RESET_CHECK, OP_PUSH, OP_POP, OP_MIXED, OP_FLUSH, OP_IDLE
  } op_t;

  typedef enum int {
    CHK_NONE, CHK_IDLE_STATE, CHK_LATENCY, CHK_ACCEPT, CHK_READY_LOW, CHK_EMPTY
  } chk_t;

  // One stimulus row with its expected check
  typedef struct packed {
    op_t  op;
    int   cycles;
    int   push_rate;
    int   pop_rate;
    chk_t chk;
    int   value;
  } row_t;

  logic            clk;
  logic            rst;
  logic            push_valid;
  logic            push_ready;
  fifo_pkg::data_t push_data;
  logic            pop_valid;
  logic            pop_ready;
  fifo_pkg::data_t pop_data;
  logic            flush;

  row_t            rows [$];
  fifo_pkg::data_t ref_q [$];
  int              data_errors = 0;
  int              check_errors = 0;
  int              cycle_count = 0;
  int              cycle_limit = 0;
  logic            hold_check_en = 1'b1;
  logic            prev_stall = 1'b0;
  fifo_pkg::data_t prev_data = '0;
  int unsigned     seed_init;

  tb_clock #(.period_ns(40)) clock_i (.clk(clk));

  flop_fifo flop_fifo_i (
    .clk        (clk),
    .rst        (rst),
    .push_valid (push_valid),
    .push_ready (push_ready),
    .push_data  (push_data),
    .pop_valid  (pop_valid),
    .pop_ready  (pop_ready),
    .pop_data   (pop_data),
    .flush      (flush)
  );

  // ------------------------------------------------------------
  // Helpers
  // ------------------------------------------------------------
  function automatic logic chance(input int rate);
    return int'($urandom % 100) < rate;
  endfunction

  function automatic void add_row(input op_t op, input int cycles, input int push_rate,
                                  input int pop_rate, input chk_t chk, input int value);
    rows.push_back(row_t'{op, cycles, push_rate, pop_rate, chk, value});
  endfunction

  // Drive 2 ns after the edge, sample at the falling edge
  task automatic run_cycle(input logic pv, input logic pr, input logic fl,
                           output logic pushed, output logic popped);
    fifo_pkg::data_t exp;
    @(posedge clk);
    #2;
    push_valid = pv;
    push_data  = fifo_pkg::data_t'($urandom);
    pop_ready  = pr;
    flush      = fl;
    @(negedge clk);
    pushed = push_valid && push_ready;
    popped = pop_valid && pop_ready;
    // Stalled head must not move or vanish
    if (hold_check_en && prev_stall) begin
      if (pop_valid !== 1'b1) begin
        $display("error at %0t: pop_valid expected 1 got %b", $time, pop_valid);
        check_errors++;
      end else if (pop_data !== prev_data) begin
        $display("error at %0t: pop_data expected %h got %h", $time, prev_data, pop_data);
        check_errors++;
      end
    end
    prev_stall = pop_valid && !pop_ready;
    prev_data  = pop_data;
    if (pushed) begin
      ref_q.push_back(push_data);
    end
    if (popped) begin
      if (ref_q.size() == 0) begin
        $display("pop at %0t with no entry left in the reference queue", $time);
        check_errors++;
      end else begin
        exp = ref_q.pop_front();
        if (pop_data !== exp) begin
          $display("error at %0t: pop_data expected %h got %h", $time, exp, pop_data);
          data_errors++;
        end
      end
    end
  endtask

  // Flush pulse, then wait until pushes are taken again
  task automatic run_flush(input int cycles);
    logic pushed;
    logic popped;
    logic recovered;
    hold_check_en = 1'b0;
    recovered = 1'b0;
    run_cycle(1'b0, 1'b0, 1'b1, pushed, popped);
    for (int i = 1; i < cycles && !recovered; i++) begin
      run_cycle(1'b0, 1'b0, 1'b0, pushed, popped);
      recovered = push_ready;
    end
    if (!recovered) begin
      $display("flush did not finish within %0d cycles", cycles);
      check_errors++;
    end else if (pop_valid !== 1'b0) begin
      $display("error at %0t: pop_valid expected 0 got %b", $time, pop_valid);
      check_errors++;
    end
    // Everything held before the flush is gone
    ref_q.delete();
    prev_stall = 1'b0;
    hold_check_en = 1'b1;
  endtask

  task automatic apply_row(input row_t r);
    logic pushed;
    logic popped;
    logic pv;
    logic pr;
    int   accepted;
    int   push_cycle;
    int   seen_cycle;
    accepted   = 0;
    push_cycle = -1;
    seen_cycle = -1;
    if (r.op == OP_FLUSH) begin
      run_flush(r.cycles);
    end else begin
      for (int i = 0; i < r.cycles; i++) begin
        pv = (r.op == OP_PUSH || r.op == OP_MIXED) && chance(r.push_rate);
        // Latency row sends a single entry
        if (r.chk == CHK_LATENCY && accepted > 0) begin
          pv = 1'b0;
        end
        pr = (r.op != OP_RESET_CHECK) && chance(r.pop_rate);
        run_cycle(pv, pr, 1'b0, pushed, popped);
        if (pushed) begin
          accepted++;
          if (push_cycle < 0) begin
            push_cycle = i;
          end
        end
        if (push_cycle >= 0 && seen_cycle < 0 && pop_valid === 1'b1) begin
          seen_cycle = i;
        end
        if (r.chk == CHK_READY_LOW && push_ready !== 1'b0) begin
          $display("error at %0t: push_ready expected 0 got %b", $time, push_ready);
          check_errors++;
        end
        if (r.chk == CHK_IDLE_STATE && push_ready !== 1'b1) begin
          $display("error at %0t: push_ready expected 1 got %b", $time, push_ready);
          check_errors++;
        end
        if (r.chk == CHK_IDLE_STATE && pop_valid !== 1'b0) begin
          $display("error at %0t: pop_valid expected 0 got %b", $time, pop_valid);
          check_errors++;
        end
      end
      // End of row checks
      if (r.chk == CHK_ACCEPT && accepted != r.value) begin
        $display("error at %0t: push count expected %0d got %0d", $time, r.value, accepted);
        check_errors++;
      end
      if (r.chk == CHK_LATENCY && seen_cycle < 0) begin
        $display("pop_valid never rose after the single push");
        check_errors++;
      end else if (r.chk == CHK_LATENCY && seen_cycle - push_cycle != r.value) begin
        $display("error at %0t: pop_valid latency expected %0d got %0d", $time, r.value,
                 seen_cycle - push_cycle);
        check_errors++;
      end
      if (r.chk == CHK_EMPTY && ref_q.size() != 0) begin
        $display("%0d pushed entries never came out", ref_q.size());
        check_errors++;
      end
      if (r.chk == CHK_EMPTY && pop_valid !== 1'b0) begin
        $display("error at %0t: pop_valid expected 0 got %b", $time, pop_valid);
        check_errors++;
      end
    end
  endtask

  // ------------------------------------------------------------
  // Watchdog
  // ------------------------------------------------------------
  always @(posedge clk) begin
    if (!rst) begin
      cycle_count <= cycle_count + 1;
    end
    if (cycle_limit > 0 && cycle_count >= cycle_limit) begin
      $display("run stopped after %0d cycles without reaching the end", cycle_count);
      $display("data errors %0d, check errors %0d", data_errors, check_errors);
      $display("Errors found");
      $finish;
    end
  end

  // ------------------------------------------------------------
  // Main sequence
  // ------------------------------------------------------------
  initial begin
    rst        = 1'b1;
    push_valid = 1'b0;
    push_data  = '0;
    pop_ready  = 1'b0;
    flush      = 1'b0;
    seed_init  = $urandom(61804);

    // Op, cycles, push rate, pop rate, check, value
    add_row(OP_RESET_CHECK, 1, 0, 0, CHK_IDLE_STATE, 0);
    add_row(OP_PUSH, 8, 100, 100, CHK_LATENCY, 1 + `FIFO_RD_LATENCY + 1);
    add_row(OP_MIXED, 200, 50, 50, CHK_NONE, 0);
    add_row(OP_POP, 30, 0, 100, CHK_EMPTY, 0);
    add_row(OP_PUSH, 20, 100, 0, CHK_ACCEPT, `FIFO_DEPTH + `FIFO_POP_BUF_DEPTH);
    add_row(OP_IDLE, 10, 0, 0, CHK_READY_LOW, 0);
    add_row(OP_POP, 30, 0, 100, CHK_EMPTY, 0);
    add_row(OP_MIXED, 150, 80, 30, CHK_NONE, 0);
    add_row(OP_MIXED, 150, 30, 80, CHK_NONE, 0);
    add_row(OP_MIXED, 30, 90, 10, CHK_NONE, 0);
    // Two pops from a full FIFO leave a RAM read in flight when the flush lands
    add_row(OP_POP, 2, 0, 100, CHK_NONE, 0);
    add_row(OP_FLUSH, 20, 0, 0, CHK_NONE, 0);
    add_row(OP_IDLE, 10, 0, 100, CHK_EMPTY, 0);
    add_row(OP_MIXED, 150, 60, 60, CHK_NONE, 0);
    add_row(OP_POP, 30, 0, 100, CHK_EMPTY, 0);
    add_row(OP_RESET_CHECK, 1, 0, 0, CHK_IDLE_STATE, 0);

    // Limit is the table length with some slack
    for (int i = 0; i < rows.size(); i++) begin
      cycle_limit += rows[i].cycles;
    end
    cycle_limit += 50;

    repeat (5) @(posedge clk);
    #2;
    rst = 1'b0;

    foreach (rows[i]) begin
      apply_row(rows[i]);
    end

    $display("data errors %0d, check errors %0d", data_errors, check_errors);
    if (data_errors + check_errors == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule

/* vlog.f */
+incdir+hw
hw/fifo_pkg.sv
hw/delay_valid.sv
hw/ram_flops_1r1w.sv
hw/fifo_occupancy.sv
hw/fifo_ctrl_fsm.sv
hw/fifo_pop_buffer.sv
hw/flop_fifo.sv
bench/tb_clock.sv
bench/flop_fifo_tb.sv

/* Bender.yml */
package:
  name: flop_fifo

sources:
  - include_dirs:
      - hw
    files:
      - hw/fifo_pkg.sv
      - hw/delay_valid.sv
      - hw/ram_flops_1r1w.sv
      - hw/fifo_occupancy.sv
      - hw/fifo_ctrl_fsm.sv
      - hw/fifo_pop_buffer.sv
      - hw/flop_fifo.sv
  - target: test
    include_dirs:
      - hw
    files:
      - bench/tb_clock.sv
      - bench/flop_fifo_tb.sv
